// ==== Bender.yml ====
package:
  name: vid_csc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vid_pkg.sv
      - verilog/vid_422_unpack.sv
      - verilog/vid_ycbcr2rgb.sv
      - verilog/vid_rgb_out.sv
      - verilog/vid_csc_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_vid_csc.sv

// ==== sources.f ====
+incdir+verilog
verilog/vid_pkg.sv
verilog/vid_422_unpack.sv
verilog/vid_ycbcr2rgb.sv
verilog/vid_rgb_out.sv
verilog/vid_csc_top.sv
tb/tb_clk_gen.sv
tb/tb_vid_csc.sv

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset covers the first RESET_CYCLES rising edges
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== tb/tb_vid_csc.sv ====
`timescale 1ns/1ns

`include "vid_defines.svh"

module tb_vid_csc
	import vid_pkg::*;
();

	localparam int CLK_NS      = 100;
	localparam int WATCHDOG_NS = 240 * 40 * CLK_NS; // 240 pairs, 40 cycles each
	localparam int ACK_LIMIT   = 1000;              // Cycles to wait on in_ack
	localparam int DRAIN_LIMIT = 4000;              // Cycles to wait on the last pixels

	logic         clk;
	logic         rst;
	logic         in_req;
	logic         in_ack;
	ycc422_pair_t in_data;
	logic         out_req;
	logic         out_ack;
	rgb_pix_t     out_data;

	rgb_pix_t     exp_q[$];
	integer       seed           = 32'h4a236ec2;
	integer       err_count      = 0;
	integer       rx_count       = 0;
	integer       sink_max_delay = 0;
	integer       tests_passed   = 0;
	integer       tests_failed   = 0;
	integer       test_err_start = 0;
	string        cur_test       = "none";

	tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) clk_gen_inst (.clk(clk), .rst(rst));

	vid_csc_top vid_csc_top_inst (
		.clk      (clk),
		.rst      (rst),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_data  (in_data),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_data)
	);

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	// Floor divide by 128, then clamp to 0..255
	function automatic logic [7:0] scale_sat(input integer v);
		integer q;
		q = v / (1 << `VID_SHIFT);
		if (v < 0 && q * (1 << `VID_SHIFT) != v)
			q = q - 1; // Division truncates toward zero
		if (q < 0)
			q = 0;
		else if (q > 255)
			q = 255;
		return q[7:0];
	endfunction

	function automatic rgb_pix_t model_rgb(input logic [7:0] y, input logic [7:0] cb,
		input logic [7:0] cr);
		integer   yl;
		integer   cbc;
		integer   crc;
		integer   t;
		rgb_pix_t p;
		yl  = y;
		cbc = cb;
		crc = cr;
		if (y[7:4] == 4'h0)
			yl = `VID_Y_FLOOR;
		cbc = cbc - `VID_C_MID;
		crc = crc - `VID_C_MID;
		t   = `VID_K_Y * (yl - `VID_Y_FLOOR) + `VID_ROUND;
		p.r = scale_sat(t + `VID_K_CR_R * crc);
		p.g = scale_sat(t - `VID_K_CB_G * cbc - `VID_K_CR_G * crc);
		p.b = scale_sat(t + `VID_K_CB_B * cbc);
		return p;
	endfunction

	function automatic ycc422_pair_t make_pair(input logic [7:0] cb, input logic [7:0] y0,
		input logic [7:0] cr, input logic [7:0] y1);
		ycc422_pair_t pair;
		pair.cb = cb;
		pair.y0 = y0;
		pair.cr = cr;
		pair.y1 = y1;
		return pair;
	endfunction

	function automatic rgb_pix_t make_rgb(input logic [7:0] r, input logic [7:0] g,
		input logic [7:0] b);
		rgb_pix_t p;
		p.r = r;
		p.g = g;
		p.b = b;
		return p;
	endfunction

	// ----------------------------------------
	// Checks and bookkeeping
	// ----------------------------------------

	task automatic check_rgb(input string name, input rgb_pix_t exp, input rgb_pix_t act);
		if (act !== exp)
		begin
			$display("Error: %s expected r=%0d g=%0d b=%0d, actual r=%0d g=%0d b=%0d",
				name, exp.r, exp.g, exp.b, act.r, act.g, act.b);
			err_count = err_count + 1;
		end
	endtask

	task automatic check_count(input string name, input integer exp, input integer act);
		if (act !== exp)
		begin
			$display("Error: %s expected count %0d, actual count %0d", name, exp, act);
			err_count = err_count + 1;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test       = name;
		test_err_start = err_count;
	endtask

	task automatic end_test();
		if (err_count == test_err_start)
		begin
			$display("Test %s: passed", cur_test);
			tests_passed = tests_passed + 1;
		end
		else
		begin
			$display("Test %s: failed with %0d errors", cur_test, err_count - test_err_start);
			tests_failed = tests_failed + 1;
		end
	endtask

	// ----------------------------------------
	// Source and sink
	// ----------------------------------------

	task automatic push_pair(input ycc422_pair_t pair);
		exp_q.push_back(model_rgb(pair.y0, pair.cb, pair.cr)); // Y0 leaves first
		exp_q.push_back(model_rgb(pair.y1, pair.cb, pair.cr));
	endtask

	// One full four-phase transfer of a pair
	task automatic send_pair(input ycc422_pair_t pair);
		integer n;
		@(negedge clk);
		in_data = pair;
		in_req  = 1'b1;
		n = 0;
		while (!in_ack && n < ACK_LIMIT)
		begin
			@(negedge clk);
			n = n + 1;
		end
		if (!in_ack)
		begin
			$display("Test %s: in_ack never rose for word %h", cur_test, pair);
			err_count = err_count + 1;
		end
		in_req = 1'b0;
		n = 0;
		while (in_ack && n < ACK_LIMIT)
		begin
			@(negedge clk);
			n = n + 1;
		end
		if (in_ack)
		begin
			$display("Test %s: in_ack stayed high after in_req fell", cur_test);
			err_count = err_count + 1;
		end
	endtask

	task automatic wait_pixels(input integer target);
		integer n;
		n = 0;
		while (rx_count < target && n < DRAIN_LIMIT)
		begin
			@(negedge clk);
			n = n + 1;
		end
		if (rx_count < target)
		begin
			$display("Test %s: output stalled, %0d pixels short", cur_test, target - rx_count);
			err_count = err_count + 1;
		end
		repeat (20 + sink_max_delay) @(negedge clk); // Give a stray extra pixel time to show
	endtask

	initial
	begin : sink_proc
		rgb_pix_t got;
		rgb_pix_t exp;
		integer   delay;
		forever
		begin
			@(negedge clk);
			if (out_req)
			begin
				got   = out_data;
				delay = 0;
				if (sink_max_delay > 0)
					delay = $unsigned($random(seed)) % (sink_max_delay + 1);
				repeat (delay) @(negedge clk);
				out_ack = 1'b1;
				@(negedge clk);
				while (out_req)
					@(negedge clk);
				out_ack  = 1'b0;
				rx_count = rx_count + 1;
				if (exp_q.size() == 0)
				begin
					$display("Test %s: pixel %h arrived with nothing expected", cur_test, got);
					err_count = err_count + 1;
				end
				else
				begin
					exp = exp_q.pop_front();
					check_rgb(cur_test, exp, got);
				end
			end
		end
	end

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------

	task automatic test_reset_state();
		integer high_cycles;
		begin_test("reset_state");
		high_cycles = 0;
		repeat (20)
		begin
			@(negedge clk);
			if (out_req !== 1'b0 || in_ack !== 1'b0)
				high_cycles = high_cycles + 1;
		end
		check_count(cur_test, 0, high_cycles);
		end_test();
	endtask

	task automatic test_known_colours();
		ycc422_pair_t pair;
		integer       base;
		begin_test("known_colours");
		base = rx_count;
		pair = make_pair(8'd128, 8'd16, 8'd128, 8'd235);   // Black then white
		exp_q.push_back(make_rgb(8'd0, 8'd0, 8'd0));
		exp_q.push_back(make_rgb(8'd255, 8'd255, 8'd255));
		send_pair(pair);
		pair = make_pair(8'd128, 8'd235, 8'd128, 8'd16);   // Swapped order
		exp_q.push_back(make_rgb(8'd255, 8'd255, 8'd255));
		exp_q.push_back(make_rgb(8'd0, 8'd0, 8'd0));
		send_pair(pair);
		pair = make_pair(8'd90, 8'd81, 8'd240, 8'd82);     // Saturated red
		push_pair(pair);
		send_pair(pair);
		wait_pixels(base + 6);
		check_count(cur_test, 6, rx_count - base);
		end_test();
	endtask

	task automatic test_luma_floor();
		ycc422_pair_t pair;
		rgb_pix_t     floor_ref;
		integer       base;
		begin_test("luma_floor");
		base      = rx_count;
		floor_ref = model_rgb(8'd16, 8'd110, 8'd150);
		// Anything below 16 reads as black level
		pair = make_pair(8'd110, 8'd0, 8'd150, 8'd5);
		exp_q.push_back(floor_ref);
		exp_q.push_back(floor_ref);
		send_pair(pair);
		pair = make_pair(8'd110, 8'd15, 8'd150, 8'd16);
		exp_q.push_back(floor_ref);
		exp_q.push_back(floor_ref);
		send_pair(pair);
		pair = make_pair(8'd110, 8'd17, 8'd150, 8'd17);
		push_pair(pair);
		send_pair(pair);
		wait_pixels(base + 6);
		check_count(cur_test, 6, rx_count - base);
		end_test();
	endtask

	task automatic test_saturation();
		ycc422_pair_t pair;
		integer       base;
		begin_test("saturation");
		base = rx_count;
		pair = make_pair(8'd255, 8'd235, 8'd255, 8'd16);
		exp_q.push_back(make_rgb(8'd255, 8'd101, 8'd255)); // R and B above 255
		exp_q.push_back(make_rgb(8'd202, 8'd0, 8'd254));   // G below 0
		send_pair(pair);
		pair = make_pair(8'd0, 8'd16, 8'd0, 8'd235);
		exp_q.push_back(make_rgb(8'd0, 8'd155, 8'd0));     // R and B below 0
		exp_q.push_back(make_rgb(8'd51, 8'd255, 8'd0));    // G above 255
		send_pair(pair);
		wait_pixels(base + 4);
		check_count(cur_test, 4, rx_count - base);
		end_test();
	endtask

	task automatic random_pairs(input string name, input integer pairs, input integer delay);
		ycc422_pair_t pair;
		integer       base;
		begin_test(name);
		base           = rx_count;
		sink_max_delay = delay;
		repeat (pairs)
		begin
			pair = $random(seed);
			push_pair(pair);
			send_pair(pair);
		end
		wait_pixels(base + 2 * pairs);
		check_count(cur_test, 2 * pairs, rx_count - base);
		sink_max_delay = 0;
		end_test();
	endtask

	// ----------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------

	initial
	begin
		in_req  = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		wait (rst === 1'b0);
		@(negedge clk);
		test_reset_state();
		test_known_colours();
		test_luma_floor();
		test_saturation();
		random_pairs("random_stream", 100, 0);
		random_pairs("back_pressure", 40, 30);
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verilog/vid_422_unpack.sv ====
`timescale 1ns/1ns

module vid_422_unpack
	import vid_pkg::*;
(
	input  logic         clk,
	input  logic         rst,

	// Four-phase input
	input  logic         in_req,
	output logic         in_ack,
	input  ycc422_pair_t in_data,

	// To converter
	output ycc_pix_t     pix,
	output logic         pix_valid,

	// From output side
	input  logic         credit
);

	// ----------------------------------------
	// Handshake FSM
	// ----------------------------------------

	localparam logic HS_IDLE = 1'b0;
	localparam logic HS_ACK  = 1'b1;

	logic         hs_state;
	logic         take_word;

	// Word holder
	ycc422_pair_t hold;
	logic         hold_full;
	logic         hold_phase;

	// Only accept a new word when the holder has drained
	assign take_word = (hs_state == HS_IDLE) && in_req && !hold_full;

	always_ff @(posedge clk)
	begin
		if (rst)
			hs_state <= HS_IDLE;
		else
		begin
			case (hs_state)
				HS_IDLE:
					if (take_word)
						hs_state <= HS_ACK;
				HS_ACK:
					if (!in_req)
						hs_state <= HS_IDLE; // Source released, drop ack
				default:
					hs_state <= HS_IDLE;
			endcase
		end
	end

	assign in_ack = (hs_state == HS_ACK);

	// ----------------------------------------
	// Holder and pixel issue
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (take_word)
			hold <= in_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hold_full  <= 1'b0;
			hold_phase <= 1'b0;
		end
		else if (take_word)
		begin
			hold_full  <= 1'b1;
			hold_phase <= 1'b0; // Y0 goes first
		end
		else if (pix_valid)
		begin
			if (hold_phase)
				hold_full <= 1'b0; // Y1 issued, pair done
			hold_phase <= ~hold_phase;
		end
	end

	// Issue only while the output side has room reserved
	assign pix_valid = hold_full && credit;

	always_comb
	begin
		pix.y     = hold_phase ? hold.y1 : hold.y0;
		pix.cb    = hold.cb;   // Chroma is shared by both pixels
		pix.cr    = hold.cr;
		pix.phase = hold_phase;
	end

endmodule

// ==== verilog/vid_csc_top.sv ====
`timescale 1ns/1ns

module vid_csc_top
	import vid_pkg::*;
(
	input  logic         clk,
	input  logic         rst,

	// YCbCr pair source
	input  logic         in_req,
	output logic         in_ack,
	input  ycc422_pair_t in_data,

	// RGB pixel sink
	output logic         out_req,
	input  logic         out_ack,
	output rgb_pix_t     out_data
);

	ycc_pix_t pix;
	logic     pix_valid;
	logic     credit;
	rgb_pix_t rgb;
	logic     rgb_valid;

	vid_422_unpack unpack_inst (
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_data   (in_data),
		.pix       (pix),
		.pix_valid (pix_valid),
		.credit    (credit)
	);

	vid_ycbcr2rgb csc_inst (
		.clk       (clk),
		.rst       (rst),
		.pix       (pix),
		.pix_valid (pix_valid),
		.rgb       (rgb),
		.rgb_valid (rgb_valid)
	);

	// Same strobe also reserves a FIFO slot
	vid_rgb_out out_inst (
		.clk       (clk),
		.rst       (rst),
		.rgb       (rgb),
		.rgb_valid (rgb_valid),
		.pix_valid (pix_valid),
		.credit    (credit),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_data  (out_data)
	);

endmodule

// ==== verilog/vid_defines.svh ====
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// ----------------------------------------
// Result buffering
// ----------------------------------------

`define VID_FIFO_DEPTH  8     // Result FIFO entries
`define VID_FIFO_AW     3     // FIFO address width
`define VID_CSC_LAT     5     // Converter latency in cycles

// ----------------------------------------
// Conversion coefficients, scaled by 128
// ----------------------------------------

`define VID_K_Y         149
`define VID_K_CB_G      51
`define VID_K_CB_B      256
`define VID_K_CR_R      204
`define VID_K_CR_G      104

// Offsets and final scaling
`define VID_Y_FLOOR     16    // Black level of luma
`define VID_C_MID       128   // Chroma zero point
`define VID_ROUND       64    // Half LSB after the shift
`define VID_SHIFT       7

`endif

// ==== verilog/vid_pkg.sv ====
package vid_pkg;

	// ----------------------------------------
	// Stream word types
	// ----------------------------------------

	// 4:2:2 input word, Cb in the top byte
	typedef struct packed
	{
		logic [7:0] cb;
		logic [7:0] y0;
		logic [7:0] cr;
		logic [7:0] y1;
	} ycc422_pair_t;

	// One pixel on its way into the converter
	typedef struct packed
	{
		logic [7:0] y;     // Luma already selected from the pair
		logic [7:0] cb;
		logic [7:0] cr;
		logic       phase; // 0 for Y0, 1 for Y1
	} ycc_pix_t;

	// Converted output pixel
	typedef struct packed
	{
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_pix_t;

endpackage

// ==== verilog/vid_rgb_out.sv ====
`timescale 1ns/1ns

`include "vid_defines.svh"

module vid_rgb_out
	import vid_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// From converter
	input  rgb_pix_t rgb,
	input  logic     rgb_valid,

	// Reservation strobe and credit back to input side
	input  logic     pix_valid,
	output logic     credit,

	// Four-phase output
	output logic     out_req,
	input  logic     out_ack,
	output rgb_pix_t out_data
);

	localparam int AW = `VID_FIFO_AW;
	localparam int CW = `VID_FIFO_AW + 1;
	localparam int IW = $clog2(`VID_CSC_LAT + 1);

	localparam logic [1:0] TX_IDLE = 2'd0;
	localparam logic [1:0] TX_REQ  = 2'd1;
	localparam logic [1:0] TX_DONE = 2'd2;

	rgb_pix_t        fifo_mem [`VID_FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic [IW-1:0]   inflight;
	logic [CW:0]     reserved;
	logic [1:0]      tx_state;
	logic            pop;

	// ----------------------------------------
	// Result FIFO
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rgb_valid)
			fifo_mem[wr_ptr] <= rgb;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (rgb_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({rgb_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Pixels between issue and FIFO write
	always_ff @(posedge clk)
	begin
		if (rst)
			inflight <= '0;
		else
		begin
			case ({pix_valid, rgb_valid})
				2'b10:   inflight <= inflight + 1'b1;
				2'b01:   inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

	assign reserved = {1'b0, count} + (CW + 1)'(inflight);
	assign credit   = reserved < `VID_FIFO_DEPTH; // Room for one more

	// ----------------------------------------
	// Output handshake
	// ----------------------------------------

	assign pop = (tx_state == TX_REQ) && out_ack;

	always_ff @(posedge clk)
	begin
		if (rst)
			tx_state <= TX_IDLE;
		else
		begin
			case (tx_state)
				TX_IDLE: if (count != '0) tx_state <= TX_REQ;
				TX_REQ:  if (out_ack) tx_state <= TX_DONE;  // Sink took the head
				TX_DONE: if (!out_ack) tx_state <= TX_IDLE;
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign out_req  = (tx_state == TX_REQ);
	assign out_data = fifo_mem[rd_ptr]; // Head stays put until popped

endmodule

// ==== verilog/vid_ycbcr2rgb.sv ====
`timescale 1ns/1ns

`include "vid_defines.svh"

module vid_ycbcr2rgb
	import vid_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// Pixel in
	input  ycc_pix_t pix,
	input  logic     pix_valid,

	// Pixel out, 5 cycles later
	output rgb_pix_t rgb,
	output logic     rgb_valid
);

	// Wide enough for Y at 255 plus full positive Cb term
	localparam int SUM_W = 18;

	localparam logic signed [SUM_W-1:0] K_Y    = `VID_K_Y;
	localparam logic signed [SUM_W-1:0] K_CB_G = `VID_K_CB_G;
	localparam logic signed [SUM_W-1:0] K_CB_B = `VID_K_CB_B;
	localparam logic signed [SUM_W-1:0] K_CR_R = `VID_K_CR_R;
	localparam logic signed [SUM_W-1:0] K_CR_G = `VID_K_CR_G;
	localparam logic signed [SUM_W-1:0] ROUND  = `VID_ROUND;

	// Scale down and clamp to 0..255
	function automatic logic [7:0] sat8(input logic signed [SUM_W-1:0] s);
		logic signed [SUM_W-1:0] q;
		q = s >>> `VID_SHIFT;
		if (q < 0)
			sat8 = 8'h00;
		else if (q > 255)
			sat8 = 8'hff;
		else
			sat8 = q[7:0];
	endfunction

	// Stage 1: floored luma minus black level, centred chroma
	logic        [7:0]       y_1;
	logic signed [8:0]       cb_1;
	logic signed [8:0]       cr_1;

	// Stage 2: products
	logic signed [SUM_W-1:0] py_2;
	logic signed [SUM_W-1:0] pcr_r_2;
	logic signed [SUM_W-1:0] pcb_g_2;
	logic signed [SUM_W-1:0] pcr_g_2;
	logic signed [SUM_W-1:0] pcb_b_2;

	// Stage 3: green intermediate, others delayed
	logic signed [SUM_W-1:0] py_3;
	logic signed [SUM_W-1:0] pcr_r_3;
	logic signed [SUM_W-1:0] pcb_b_3;
	logic signed [SUM_W-1:0] g_mid_3;

	// Stage 4: final sums
	logic signed [SUM_W-1:0] r_sum_4;
	logic signed [SUM_W-1:0] g_sum_4;
	logic signed [SUM_W-1:0] b_sum_4;

	logic                    v_1;
	logic                    v_2;
	logic                    v_3;
	logic                    v_4;

	// ----------------------------------------
	// Valid chain
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v_1       <= 1'b0;
			v_2       <= 1'b0;
			v_3       <= 1'b0;
			v_4       <= 1'b0;
			rgb_valid <= 1'b0;
		end
		else
		begin
			v_1       <= pix_valid;
			v_2       <= v_1;
			v_3       <= v_2;
			v_4       <= v_3;
			rgb_valid <= v_4;
		end
	end

	// ----------------------------------------
	// Data path
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		// Luma below 16 is clamped to black
		if (pix.y[7:4] == 4'h0)
			y_1 <= 8'd0;
		else
			y_1 <= pix.y - 8'(`VID_Y_FLOOR);
		cb_1 <= $signed({1'b0, pix.cb}) - 9'(`VID_C_MID);
		cr_1 <= $signed({1'b0, pix.cr}) - 9'(`VID_C_MID);

		py_2    <= K_Y * $signed({1'b0, y_1});
		pcr_r_2 <= K_CR_R * cr_1;
		pcb_g_2 <= K_CB_G * cb_1;
		pcr_g_2 <= K_CR_G * cr_1;
		pcb_b_2 <= K_CB_B * cb_1;

		py_3    <= py_2 + ROUND; // Rounding folded into the luma term
		pcr_r_3 <= pcr_r_2;
		pcb_b_3 <= pcb_b_2;
		g_mid_3 <= pcb_g_2 + pcr_g_2;

		r_sum_4 <= py_3 + pcr_r_3;
		g_sum_4 <= py_3 - g_mid_3;
		b_sum_4 <= py_3 + pcb_b_3;

		rgb.r   <= sat8(r_sum_4);
		rgb.g   <= sat8(g_sum_4);
		rgb.b   <= sat8(b_sum_4);
	end

endmodule
